//--- verilog/trs_pkg.sv
package trs_pkg;

  typedef logic [7:0]  byte_t;      // spi and z80 data bus
  typedef logic [15:0] z80_addr_t;
  typedef logic [14:0] mem_addr_t;  // 32k ram window
  typedef logic [2:0]  bp_idx_t;

  // eight slot addresses, slot 0 in the low word
  typedef z80_addr_t [7:0] bp_table_t;

  // host command codes, gaps are commands this core does not carry
  typedef enum logic [7:0] {
    get_cookie          = 8'd0,
    bram_poke           = 8'd1,   // addr_lo, addr_hi, data
    bram_peek           = 8'd2,   // addr_lo, addr_hi
    set_breakpoint      = 8'd6,   // idx, addr_lo, addr_hi
    clear_breakpoint    = 8'd7,   // idx
    enable_breakpoints  = 8'd11,
    disable_breakpoints = 8'd12,
    resume              = 8'd13,
    set_full_addr       = 8'd14,  // flag
    get_version         = 8'd15
  } cmd_t;

  typedef enum logic {
    idle,
    read_bytes
  } dec_state_t;

  localparam byte_t      COOKIE        = 8'haf;
  localparam logic [2:0] VERSION_MAJOR = 3'd0;
  localparam logic [4:0] VERSION_MINOR = 5'd3;

  // longest parameter list (poke, set_breakpoint)
  localparam int MAX_PARAMS = 3;

endpackage

//--- verilog/trs_ifs.sv
`timescale 1ns/1ps

// byte level link between the spi shifter and the command decoder
interface spi_byte_if;
  import trs_pkg::*;

  byte_t rx_byte;    // valid with rx_valid
  logic  rx_valid;   // 1 clk, eighth bit sampled
  logic  msg_start;  // 1 clk, cs_n fell
  byte_t tx_byte;
  logic  tx_load;    // 1 clk, latch tx_byte for the next transfer

  modport target  (output rx_byte, rx_valid, msg_start, input tx_byte, tx_load);
  modport decoder (input rx_byte, rx_valid, msg_start, output tx_byte, tx_load);
endinterface

// decoded command, broadcast to the register and bus blocks
interface cmd_if;
  import trs_pkg::*;

  logic  action;     // 1 clk strobe, command complete
  cmd_t  cmd;
  byte_t p0;
  byte_t p1;
  byte_t p2;

  modport source   (output action, cmd, p0, p1, p2);
  modport listener (input action, cmd, p0, p1, p2);
endinterface

//--- verilog/spi_target.sv
`timescale 1ns/1ps

module spi_target (
  input  logic        clk,
  input  logic        reset,
  input  logic        sck,
  input  logic        cs_n,
  input  logic        mosi,
  output logic        miso,
  spi_byte_if.target  sb
);
  import trs_pkg::*;

  logic [2:0] sck_s;     // 3 stage synchronisers
  logic [2:0] cs_s;
  logic [2:0] mosi_s;
  logic       sck_q;     // previous synced sck for edges
  logic       cs_q;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;
  logic [2:0] bit_cnt;
  byte_t      rx_shift;
  logic       rx_valid;
  byte_t      tx_hold;   // response waiting for the next falling edges
  byte_t      tx_shift;
  logic [3:0] tx_bits;   // falling edges left to send

  always_ff @(posedge clk) begin
    if (reset) begin
      sck_s <= '0;
      cs_s  <= '1;  // deselected
      sck_q <= 1'b0;
      cs_q  <= 1'b1;
    end else begin
      sck_s <= {sck_s[1:0], sck};
      cs_s  <= {cs_s[1:0], cs_n};
      sck_q <= sck_s[2];
      cs_q  <= cs_s[2];
    end
  end

  always_ff @(posedge clk) mosi_s <= {mosi_s[1:0], mosi};

  assign sck_rise  = sck_s[2] & ~sck_q;
  assign sck_fall  = ~sck_s[2] & sck_q;
  assign cs_active = ~cs_s[2];
  assign sb.msg_start = cs_q & ~cs_s[2];  // cs_n falling

  // receive side, msb first on rising sck
  always_ff @(posedge clk) begin
    if (reset) begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= cs_active && sck_rise && (bit_cnt == 3'd7);
      if (!cs_active)
        bit_cnt <= '0;           // realign on every message
      else if (sck_rise)
        bit_cnt <= bit_cnt + 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (cs_active && sck_rise)
      rx_shift <= {rx_shift[6:0], mosi_s[2]};
  end

  assign sb.rx_byte  = rx_shift;
  assign sb.rx_valid = rx_valid;

  // transmit side
  always_ff @(posedge clk) begin
    if (sb.tx_load)
      tx_hold <= sb.tx_byte;
  end

  always_ff @(posedge clk) begin
    if (reset || !cs_active) begin
      tx_bits  <= '0;
      tx_shift <= '0;
    end else if (sb.tx_load) begin
      tx_bits <= 4'd8;
    end else if (sck_fall) begin
      if (tx_bits != 4'd0) begin
        // first edge puts bit 7 out, then shift left
        tx_shift <= (tx_bits == 4'd8) ? tx_hold : {tx_shift[6:0], 1'b0};
        tx_bits  <= tx_bits - 4'd1;
      end else begin
        tx_shift <= '0;          // nothing queued, idle low
      end
    end
  end

  assign miso = tx_shift[7];

endmodule

//--- verilog/cmd_decoder.sv
`timescale 1ns/1ps

module cmd_decoder #(
  parameter int MEM_ADDR_W = 15
) (
  input  logic                  clk,
  input  logic                  reset,
  spi_byte_if.decoder           sb,
  cmd_if.source                 cb,
  output logic                  ram_en,
  output logic                  ram_we,
  output logic [MEM_ADDR_W-1:0] ram_addr,
  output trs_pkg::byte_t        ram_wdata,
  input  trs_pkg::byte_t        ram_rdata
);
  import trs_pkg::*;

  dec_state_t state;
  cmd_t       cmd_r;
  cmd_t       rx_cmd;
  byte_t      params [MAX_PARAMS];
  logic [1:0] param_idx;
  logic [1:0] params_left;
  logic [1:0] n_params;      // parameter bytes for rx_cmd
  logic       known;
  logic       action;
  logic       resp_pending;  // next transfer carries our response
  logic       peek_rd;       // port b read data valid
  z80_addr_t  host_addr;

  assign rx_cmd = cmd_t'(sb.rx_byte);

  always_comb begin
    known    = 1'b1;
    n_params = 2'd0;
    case (rx_cmd)
      bram_poke, set_breakpoint:       n_params = 2'd3;
      bram_peek:                       n_params = 2'd2;
      clear_breakpoint, set_full_addr: n_params = 2'd1;
      get_cookie, get_version, enable_breakpoints, disable_breakpoints, resume:
        n_params = 2'd0;
      default: known = 1'b0;          // unknown code, dropped
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= idle;
      cmd_r        <= get_cookie;
      param_idx    <= '0;
      params_left  <= '0;
      action       <= 1'b0;
      resp_pending <= 1'b0;
    end else begin
      action <= 1'b0;
      if (sb.msg_start) begin
        state        <= idle;         // new message, drop any partial one
        resp_pending <= 1'b0;
      end else if (sb.rx_valid && resp_pending) begin
        resp_pending <= 1'b0;         // mosi of the response byte ignored
      end else if (sb.rx_valid) begin
        case (state)
          idle: begin
            param_idx <= '0;
            if (known) begin
              cmd_r <= rx_cmd;
              if (n_params == 2'd0) begin
                action       <= 1'b1;
                resp_pending <= (rx_cmd == get_cookie) || (rx_cmd == get_version);
              end else begin
                params_left <= n_params;
                state       <= read_bytes;
              end
            end
          end
          read_bytes: begin
            param_idx <= param_idx + 2'd1;
            if (params_left == 2'd1) begin
              action       <= 1'b1;   // last parameter in
              resp_pending <= (cmd_r == bram_peek);
              state        <= idle;
            end else begin
              params_left <= params_left - 2'd1;
            end
          end
          default: state <= idle;
        endcase
      end
    end
  end

  // parameter capture
  always_ff @(posedge clk) begin
    if (sb.rx_valid && !resp_pending && state == read_bytes)
      params[param_idx] <= sb.rx_byte;
  end

  assign cb.action = action;
  assign cb.cmd    = cmd_r;
  assign cb.p0     = params[0];
  assign cb.p1     = params[1];
  assign cb.p2     = params[2];

  // ram port b, one clk after action
  always_ff @(posedge clk) begin
    if (reset) begin
      ram_en  <= 1'b0;
      ram_we  <= 1'b0;
      peek_rd <= 1'b0;
    end else begin
      ram_en  <= action && (cmd_r == bram_poke || cmd_r == bram_peek);
      ram_we  <= action && (cmd_r == bram_poke);
      peek_rd <= ram_en && !ram_we;  // registered read lands now
    end
  end

  assign host_addr = {params[1], params[0]};
  assign ram_addr  = host_addr[MEM_ADDR_W-1:0];
  assign ram_wdata = params[2];

  // response byte selection
  always_ff @(posedge clk) begin
    if (reset) begin
      sb.tx_load <= 1'b0;
    end else begin
      sb.tx_load <= 1'b0;
      if (action && cmd_r == get_cookie) begin
        sb.tx_byte <= COOKIE;
        sb.tx_load <= 1'b1;
      end else if (action && cmd_r == get_version) begin
        sb.tx_byte <= {VERSION_MAJOR, VERSION_MINOR};
        sb.tx_load <= 1'b1;
      end else if (peek_rd) begin
        sb.tx_byte <= ram_rdata;      // 3 clk after action
        sb.tx_load <= 1'b1;
      end
    end
  end

endmodule

//--- verilog/bus_config.sv
`timescale 1ns/1ps

module bus_config #(
  parameter int NUM_BP = 8
) (
  input  logic               clk,
  input  logic               reset,
  cmd_if.listener            cb,
  output logic               full_addr,
  output logic               bp_enabled,
  output logic [NUM_BP-1:0]  bp_active,
  output trs_pkg::bp_table_t bp_table
);
  import trs_pkg::*;

  bp_idx_t slot;

  assign slot = bp_idx_t'(cb.p0 % NUM_BP);  // index wraps to table size

  // control flags
  always_ff @(posedge clk) begin
    if (reset) begin
      full_addr  <= 1'b0;
      bp_enabled <= 1'b0;
      bp_active  <= '0;
    end else if (cb.action) begin
      case (cb.cmd)
        set_full_addr:       full_addr <= (cb.p0 != 8'd0);
        set_breakpoint:      bp_active[slot] <= 1'b1;
        clear_breakpoint:    bp_active[slot] <= 1'b0;
        enable_breakpoints:  bp_enabled <= 1'b1;
        disable_breakpoints: bp_enabled <= 1'b0;
        default: ;
      endcase
    end
  end

  // slot addresses, only meaningful while active
  always_ff @(posedge clk) begin
    if (cb.action && cb.cmd == set_breakpoint)
      bp_table[slot] <= {cb.p2, cb.p1};  // addr_hi, addr_lo
  end

endmodule

//--- verilog/bus_access.sv
`timescale 1ns/1ps

module bus_access #(
  parameter int MEM_ADDR_W = 15,
  parameter int NUM_BP     = 8
) (
  input  logic                  clk,
  input  logic                  reset,
  input  trs_pkg::z80_addr_t    addr,
  input  trs_pkg::byte_t        data_in,
  input  logic                  rd_n,
  input  logic                  wr_n,
  input  logic                  full_addr,
  input  logic                  bp_enabled,
  input  logic [NUM_BP-1:0]     bp_active,
  input  trs_pkg::bp_table_t    bp_table,
  cmd_if.listener               cb,
  input  trs_pkg::byte_t        ram_rdata,
  output logic                  ram_en,
  output logic                  ram_we,
  output logic [MEM_ADDR_W-1:0] ram_addr,
  output trs_pkg::byte_t        ram_wdata,
  output trs_pkg::byte_t        data_out,
  output logic                  data_oe,
  output logic                  bp_hit,
  output trs_pkg::bp_idx_t      bp_idx
);
  import trs_pkg::*;

  localparam int RD = 1;  // strobe vector bit positions
  localparam int WR = 0;

  logic [1:0] strb_s0;
  logic [1:0] strb_s1;
  logic [1:0] strb_q;     // previous synced sample
  logic [1:0] strb_f;     // filtered level
  logic [1:0] strb_fall;
  logic [1:0] agree;
  logic       rom_sel;
  logic       ram_sel;
  logic       mem_sel;
  logic       rd_access;
  logic       wr_access;
  logic       rd_pend;
  logic       resume_q;
  logic       match;
  bp_idx_t    match_idx;

  // rd_n and wr_n share one sync + filter path
  always_ff @(posedge clk) begin
    if (reset) begin
      strb_s0   <= '1;
      strb_s1   <= '1;
      strb_q    <= '1;
      strb_f    <= '1;
      strb_fall <= '0;
    end else begin
      strb_s0   <= {rd_n, wr_n};
      strb_s1   <= strb_s0;
      strb_q    <= strb_s1;
      strb_f    <= (agree & strb_s1) | (~agree & strb_f);  // two equal samples to move
      strb_fall <= agree & ~strb_s1 & strb_f;
    end
  end

  assign agree = ~(strb_s1 ^ strb_q);

  // rom only in full address mode, low 12k
  assign rom_sel = full_addr & ~addr[15] & ~addr[14] & ~(addr[13] & addr[12]);
  assign ram_sel = full_addr ? (addr[15] | addr[14]) : addr[15];
  assign mem_sel = rom_sel | ram_sel;

  assign rd_access = strb_fall[RD] & mem_sel;
  assign wr_access = strb_fall[WR] & ram_sel;  // rom area not writable

  // port a, one access per filtered falling strobe
  assign ram_en    = rd_access | wr_access;
  assign ram_we    = wr_access;
  assign ram_addr  = addr[MEM_ADDR_W-1:0];  // rom aliases onto the same ram
  assign ram_wdata = data_in;

  always_ff @(posedge clk) begin
    if (reset)
      rd_pend <= 1'b0;
    else
      rd_pend <= rd_access;
  end

  always_ff @(posedge clk) begin
    if (rd_pend)
      data_out <= ram_rdata;
  end

  assign data_oe = ~rd_n & mem_sel;

  // lowest matching slot wins
  always_comb begin
    match     = 1'b0;
    match_idx = '0;
    for (int i = 0; i < NUM_BP; i++) begin
      if (!match && bp_active[i] && bp_table[i] == addr) begin
        match     = 1'b1;
        match_idx = bp_idx_t'(i);
      end
    end
  end

  // stop flag, held until resume
  always_ff @(posedge clk) begin
    if (reset) begin
      resume_q <= 1'b0;
      bp_hit   <= 1'b0;
      bp_idx   <= '0;
    end else begin
      resume_q <= cb.action && cb.cmd == resume;
      if (resume_q) begin
        bp_hit <= 1'b0;
        bp_idx <= '0;
      end else if (rd_access && bp_enabled && !bp_hit && match) begin
        bp_hit <= 1'b1;
        bp_idx <= match_idx;
      end
    end
  end

endmodule

//--- verilog/dual_port_ram.sv
`timescale 1ns/1ps

module dual_port_ram #(
  parameter int MEM_ADDR_W = 15
) (
  input  logic                  clk,
  input  logic                  en_a,
  input  logic                  we_a,
  input  logic [MEM_ADDR_W-1:0] addr_a,
  input  logic [7:0]            wdata_a,
  output logic [7:0]            rdata_a,
  input  logic                  en_b,
  input  logic                  we_b,
  input  logic [MEM_ADDR_W-1:0] addr_b,
  input  logic [7:0]            wdata_b,
  output logic [7:0]            rdata_b
);

  logic [7:0] mem [2**MEM_ADDR_W];

  // both ports in one process, read returns old data
  always_ff @(posedge clk) begin
    if (en_a) begin
      if (we_a)
        mem[addr_a] <= wdata_a;  // z80 side
      rdata_a <= mem[addr_a];
    end
    if (en_b) begin
      if (we_b)
        mem[addr_b] <= wdata_b;  // host side
      rdata_b <= mem[addr_b];
    end
  end

endmodule

//--- verilog/trs_io_top.sv
`timescale 1ns/1ps

module trs_io_top #(
  parameter int MEM_ADDR_W = $bits(trs_pkg::mem_addr_t),
  parameter int NUM_BP     = 8
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               sck,
  input  logic               cs_n,
  input  logic               mosi,
  output logic               miso,
  input  trs_pkg::z80_addr_t addr,
  input  trs_pkg::byte_t     data_in,
  input  logic               rd_n,
  input  logic               wr_n,
  output trs_pkg::byte_t     data_out,
  output logic               data_oe,
  output logic               bp_hit,
  output trs_pkg::bp_idx_t   bp_idx
);
  import trs_pkg::*;

  logic                  full_addr;
  logic                  bp_enabled;
  logic [NUM_BP-1:0]     bp_active;
  bp_table_t             bp_table;
  logic                  ram_a_en;    // z80 side
  logic                  ram_a_we;
  logic [MEM_ADDR_W-1:0] ram_a_addr;
  byte_t                 ram_a_wdata;
  byte_t                 ram_a_rdata;
  logic                  ram_b_en;    // host side
  logic                  ram_b_we;
  logic [MEM_ADDR_W-1:0] ram_b_addr;
  byte_t                 ram_b_wdata;
  byte_t                 ram_b_rdata;

  spi_byte_if sb_if ();
  cmd_if      cmd_bus ();

  spi_target u_spi (
    .clk   (clk),
    .reset (reset),
    .sck   (sck),
    .cs_n  (cs_n),
    .mosi  (mosi),
    .miso  (miso),
    .sb    (sb_if)
  );

  cmd_decoder #(.MEM_ADDR_W(MEM_ADDR_W)) u_dec (
    .clk       (clk),
    .reset     (reset),
    .sb        (sb_if),
    .cb        (cmd_bus),
    .ram_en    (ram_b_en),
    .ram_we    (ram_b_we),
    .ram_addr  (ram_b_addr),
    .ram_wdata (ram_b_wdata),
    .ram_rdata (ram_b_rdata)
  );

  bus_config #(.NUM_BP(NUM_BP)) u_cfg (
    .clk        (clk),
    .reset      (reset),
    .cb         (cmd_bus),
    .full_addr  (full_addr),
    .bp_enabled (bp_enabled),
    .bp_active  (bp_active),
    .bp_table   (bp_table)
  );

  bus_access #(.MEM_ADDR_W(MEM_ADDR_W), .NUM_BP(NUM_BP)) u_bus (
    .clk        (clk),
    .reset      (reset),
    .addr       (addr),
    .data_in    (data_in),
    .rd_n       (rd_n),
    .wr_n       (wr_n),
    .full_addr  (full_addr),
    .bp_enabled (bp_enabled),
    .bp_active  (bp_active),
    .bp_table   (bp_table),
    .cb         (cmd_bus),
    .ram_rdata  (ram_a_rdata),
    .ram_en     (ram_a_en),
    .ram_we     (ram_a_we),
    .ram_addr   (ram_a_addr),
    .ram_wdata  (ram_a_wdata),
    .data_out   (data_out),
    .data_oe    (data_oe),
    .bp_hit     (bp_hit),
    .bp_idx     (bp_idx)
  );

  dual_port_ram #(.MEM_ADDR_W(MEM_ADDR_W)) u_ram (
    .clk     (clk),
    .en_a    (ram_a_en),
    .we_a    (ram_a_we),
    .addr_a  (ram_a_addr),
    .wdata_a (ram_a_wdata),
    .rdata_a (ram_a_rdata),
    .en_b    (ram_b_en),
    .we_b    (ram_b_we),
    .addr_b  (ram_b_addr),
    .wdata_b (ram_b_wdata),
    .rdata_b (ram_b_rdata)
  );

endmodule

//--- dv/tb_tasks.svh
// reference model state
byte_t      mem_model [32768];  // indexed by the low 15 address bits
logic       full_mode;
logic       bp_on;
logic [7:0] slot_act;
z80_addr_t  slot_addr [8];
logic       stopped;             // z80 held at a breakpoint
bp_idx_t    stop_slot;

// ram window, a15 only unless full address mode
function automatic logic in_ram(input z80_addr_t a);
  return full_mode ? (a >= 16'h4000) : (a >= 16'h8000);
endfunction

function automatic logic in_rom(input z80_addr_t a);
  return full_mode && (a < 16'h3000);  // low 12k, read only
endfunction

task automatic check_equal(input string name, input logic [15:0] exp, input logic [15:0] act);
  checks++;
  if (act !== exp) begin
    errors++;
    $display("error %s: expected %h, actual %h", name, exp, act);
  end
endtask

task automatic end_test(input string name);
  tests++;
  if (errors == err_mark)
    $display("test %s: ok", name);
  else
    $display("test %s: %0d errors", name, errors - err_mark);
  err_mark = errors;
endtask

// mode 0 host, mosi changes in the low phase, miso read just before the rise
task automatic spi_xfer(input byte_t tx, output byte_t rx);
  byte_t sh;
  sh = tx;
  rx = 8'h00;
  for (int i = 0; i < 8; i++) begin
    mosi <= sh[7];
    sh = {sh[6:0], 1'b0};
    repeat (9) @(posedge clk);
    @(negedge clk);
    rx = {rx[6:0], miso};
    @(posedge clk);
    sck <= 1'b1;
    repeat (10) @(posedge clk);
    sck <= 1'b0;
  end
  repeat (20) @(posedge clk);  // gap between bytes
endtask

task automatic cs_low;
  cs_n <= 1'b0;
  repeat (10) @(posedge clk);
endtask

task automatic cs_high;
  cs_n <= 1'b1;
  repeat (20) @(posedge clk);
endtask

// one message, command byte plus n parameters
task automatic host_send(input byte_t cmd, input byte_t p0, input byte_t p1, input byte_t p2,
                         input int n);
  byte_t junk;
  cs_low();
  spi_xfer(cmd, junk);
  if (n > 0)
    spi_xfer(p0, junk);
  if (n > 1)
    spi_xfer(p1, junk);
  if (n > 2)
    spi_xfer(p2, junk);
  cs_high();
endtask

// cookie or version, answer shifted out on the following byte
task automatic host_query(input byte_t cmd, output byte_t resp);
  byte_t junk;
  cs_low();
  spi_xfer(cmd, junk);
  spi_xfer(8'h00, resp);
  cs_high();
endtask

task automatic host_poke(input z80_addr_t a, input byte_t d);
  host_send(bram_poke, a[7:0], a[15:8], d, 3);
  mem_model[a[14:0]] = d;  // port b writes land anywhere
endtask

task automatic host_peek(input z80_addr_t a, output byte_t d);
  byte_t junk;
  cs_low();
  spi_xfer(bram_peek, junk);
  spi_xfer(a[7:0], junk);
  spi_xfer(a[15:8], junk);
  spi_xfer(8'h00, d);  // read data comes back here
  cs_high();
endtask

task automatic host_set_bp(input bp_idx_t k, input z80_addr_t a);
  host_send(set_breakpoint, {5'd0, k}, a[7:0], a[15:8], 3);
  slot_act[k]  = 1'b1;
  slot_addr[k] = a;
endtask

// z80 read, strobe held 12 clk, bus sampled on the last one
task automatic z80_read(input z80_addr_t a, output byte_t d, output logic oe);
  addr <= a;
  @(posedge clk);
  rd_n <= 1'b0;
  repeat (11) @(posedge clk);
  @(negedge clk);
  d  = data_out;
  oe = data_oe;
  @(posedge clk);
  rd_n <= 1'b1;
  repeat (6) @(posedge clk);  // let the filter see the release
endtask

task automatic z80_write(input z80_addr_t a, input byte_t d);
  addr    <= a;
  data_in <= d;
  @(posedge clk);
  wr_n <= 1'b0;
  repeat (12) @(posedge clk);
  wr_n <= 1'b1;
  repeat (6) @(posedge clk);
endtask

task automatic apply_write(input z80_addr_t a, input byte_t d);
  if (in_ram(a))
    mem_model[a[14:0]] = d;  // rom and unmapped space ignore writes
endtask

// expected bus response, also moves the model into the stopped state
task automatic predict_read(input z80_addr_t a, output byte_t d, output logic oe);
  oe = in_ram(a) || in_rom(a);
  d  = mem_model[a[14:0]];
  if (oe && bp_on && !stopped) begin
    for (int i = 7; i >= 0; i--) begin  // downward scan, lowest slot kept
      if (slot_act[bp_idx_t'(i)] && slot_addr[bp_idx_t'(i)] == a) begin
        stopped   = 1'b1;
        stop_slot = bp_idx_t'(i);
      end
    end
  end
endtask

task automatic check_stop(input string name);
  @(negedge clk);
  check_equal({name, " bp_hit"}, 16'(stopped), 16'(bp_hit));
  if (stopped)
    check_equal({name, " bp_idx"}, 16'(stop_slot), 16'(bp_idx));
  @(posedge clk);
endtask

task automatic wait_for_bp(input logic level, input int limit, input string what);
  int n;
  n = 0;
  @(negedge clk);
  while (bp_hit !== level && n < limit) begin
    @(negedge clk);
    n++;
  end
  if (bp_hit !== level) begin
    errors++;
    $display("timeout: bp_hit did not reach %0b within %0d clk after %s", level, limit, what);
  end
  @(posedge clk);
endtask

//--- dv/tb_top.sv
`timescale 1ns/1ps

module tb_top;
  import trs_pkg::*;

  logic      clk;
  logic      reset;
  logic      sck;
  logic      cs_n;
  logic      mosi;
  logic      miso;
  z80_addr_t addr;
  byte_t     data_in;
  logic      rd_n;
  logic      wr_n;
  byte_t     data_out;
  logic      data_oe;
  logic      bp_hit;
  bp_idx_t   bp_idx;

  integer seed = 32'hc9f1bf12;
  int     tests;
  int     checks;
  int     errors;
  int     err_mark;  // error count when the last test ended

  `include "tb_tasks.svh"

  trs_io_top #(.MEM_ADDR_W(15), .NUM_BP(8)) DUT (
    .clk      (clk),
    .reset    (reset),
    .sck      (sck),
    .cs_n     (cs_n),
    .mosi     (mosi),
    .miso     (miso),
    .addr     (addr),
    .data_in  (data_in),
    .rd_n     (rd_n),
    .wr_n     (wr_n),
    .data_out (data_out),
    .data_oe  (data_oe),
    .bp_hit   (bp_hit),
    .bp_idx   (bp_idx)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  initial begin
    logic [31:0] r;
    z80_addr_t   a;
    z80_addr_t   addrs [32];
    byte_t       got;
    byte_t       exp_d;
    logic        got_oe;
    logic        exp_oe;
    bp_idx_t     k;

    reset   <= 1'b1;
    sck     <= 1'b0;
    cs_n    <= 1'b1;
    mosi    <= 1'b0;
    addr    <= '0;
    data_in <= '0;
    rd_n    <= 1'b1;
    wr_n    <= 1'b1;
    tests     = 0;
    checks    = 0;
    errors    = 0;
    err_mark  = 0;
    full_mode = 1'b0;
    bp_on     = 1'b0;
    slot_act  = '0;
    stopped   = 1'b0;
    stop_slot = '0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    repeat (5) @(posedge clk);

    @(negedge clk);
    check_equal("reset miso", 16'h0000, 16'(miso));
    check_equal("reset data_oe", 16'h0000, 16'(data_oe));
    check_equal("reset bp_hit", 16'h0000, 16'(bp_hit));
    @(posedge clk);
    end_test("reset state");

    host_query(get_cookie, got);
    check_equal("cookie", 16'h00af, 16'(got));
    host_query(get_version, got);
    check_equal("version", 16'h0003, 16'(got));  // major 0 and minor 3
    end_test("id bytes");

    for (int i = 0; i < 30; i++) begin
      r = $random(seed);
      a = r[15:0] | 16'h8000;  // ram in both decode modes
      addrs[5'(i)] = a;
      host_poke(a, r[23:16]);
    end
    for (int i = 0; i < 30; i++) begin
      a = addrs[5'(i)];
      host_peek(a, got);
      check_equal("poke then peek", 16'(mem_model[a[14:0]]), 16'(got));
      z80_read(a, got, got_oe);
      predict_read(a, exp_d, exp_oe);
      check_equal("z80 read data", 16'(exp_d), 16'(got));
      check_equal("z80 read oe", 16'(exp_oe), 16'(got_oe));
    end
    end_test("poke peek read");

    for (int i = 0; i < 12; i++) begin
      r = $random(seed);
      if (i % 2 == 0) begin
        a = r[15:0] | 16'h8000;
        host_poke(a, ~r[23:16]);  // old byte differs from the write
        z80_write(a, r[23:16]);
        apply_write(a, r[23:16]);
        host_peek(a, got);
        check_equal("z80 write a15 set", 16'(mem_model[a[14:0]]), 16'(got));
      end else begin
        a = r[15:0] & 16'h7fff;
        host_poke(a | 16'h8000, r[31:24]);  // known byte under the alias
        z80_write(a, ~r[31:24]);
        apply_write(a, ~r[31:24]);
        host_peek(a | 16'h8000, got);
        check_equal("z80 write a15 clear", 16'(mem_model[a[14:0]]), 16'(got));
        z80_read(a, got, got_oe);
        predict_read(a, exp_d, exp_oe);
        check_equal("unmapped read oe", 16'(exp_oe), 16'(got_oe));
      end
    end
    end_test("z80 writes");

    host_send(set_full_addr, 8'h01, 8'h00, 8'h00, 1);
    full_mode = 1'b1;
    r = $random(seed);
    a = r[15:0] % 16'h3000;  // rom area
    host_poke(a | 16'h8000, r[23:16]);
    z80_read(a, got, got_oe);
    predict_read(a, exp_d, exp_oe);
    check_equal("rom read data", 16'(exp_d), 16'(got));
    check_equal("rom read oe", 16'(exp_oe), 16'(got_oe));
    z80_write(a, ~r[23:16]);
    apply_write(a, ~r[23:16]);
    host_peek(a | 16'h8000, got);
    check_equal("rom write ignored", 16'(mem_model[a[14:0]]), 16'(got));
    host_poke(16'h4000, ~r[7:0]);
    z80_write(16'h4000, r[7:0]);
    apply_write(16'h4000, r[7:0]);
    host_peek(16'h4000, got);
    check_equal("write at 4000", 16'(mem_model[15'h4000]), 16'(got));
    end_test("full address");

    r = $random(seed);
    k = r[2:0];
    a = addrs[5'(r[7:4])];  // a byte the model knows
    host_set_bp(k, a);
    host_send(enable_breakpoints, 8'h00, 8'h00, 8'h00, 0);
    bp_on = 1'b1;
    z80_read(a, got, got_oe);
    predict_read(a, exp_d, exp_oe);
    check_stop("armed read");
    host_send(resume, 8'h00, 8'h00, 8'h00, 0);
    stopped = 1'b0;
    wait_for_bp(1'b0, 40, "resume");
    check_stop("after resume");
    host_send(clear_breakpoint, {5'd0, k}, 8'h00, 8'h00, 1);
    slot_act[k] = 1'b0;
    z80_read(a, got, got_oe);
    predict_read(a, exp_d, exp_oe);
    check_stop("cleared slot");
    host_set_bp(k, a);
    host_send(disable_breakpoints, 8'h00, 8'h00, 8'h00, 0);
    bp_on = 1'b0;
    z80_read(a, got, got_oe);
    predict_read(a, exp_d, exp_oe);
    check_stop("disabled");
    end_test("breakpoints");

    // poke cut off before its data byte
    a = addrs[0];
    cs_low();
    spi_xfer(bram_poke, got);
    spi_xfer(a[7:0], got);
    spi_xfer(a[15:8], got);
    cs_high();
    host_query(get_cookie, got);
    check_equal("cookie after cut", 16'h00af, 16'(got));
    host_peek(a, got);
    check_equal("cut poke target", 16'(mem_model[a[14:0]]), 16'(got));
    end_test("cut message");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

//--- list.f
+incdir+dv
verilog/trs_pkg.sv
verilog/trs_ifs.sv
verilog/spi_target.sv
verilog/cmd_decoder.sv
verilog/bus_config.sv
verilog/bus_access.sv
verilog/dual_port_ram.sv
verilog/trs_io_top.sv
dv/tb_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

# build, run, and pass only when the testbench prints its pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
